/* dv/heapGolden.txt */
// Columns, hex: action array index operand expectedError expectedResult
// Alloc result is handle<<10, Size result is size<<7, others the element
5 2 0 000 1 000
3 0 0 123 1 000
2 3 0 000 1 000
1 0 0 000 0 000
1 0 0 000 0 400
1 0 0 000 0 800
1 0 0 000 0 c00
1 0 0 000 6 000
5 0 0 000 0 000
3 0 2 5a5 0 5a5
5 0 0 000 0 180
4 0 3 000 3 000
4 0 2 000 0 5a5
3 0 0 100 0 100
8 0 0 0ff 0 1ff
9 0 0 f00 0 1ff
a 0 0 100 0 fff
b 0 0 0ff 0 fff
4 0 0 000 0 f00
8 0 3 001 3 000
c 0 2 0f0 0 5f5
d 0 2 fff 0 a0a
e 0 2 0cc 0 008
4 0 2 000 0 008
7 1 0 000 5 000
6 1 0 111 0 111
6 1 0 222 0 222
6 1 0 333 0 333
6 1 0 444 0 444
5 1 0 000 0 200
6 1 0 555 4 000
7 1 0 000 0 444
7 1 0 000 0 333
7 1 0 000 0 222
7 1 0 000 0 111
7 1 0 000 5 000
2 1 0 000 0 111
2 1 0 000 2 000
5 1 0 000 2 000
6 1 0 777 2 000
1 0 0 000 0 400
5 1 0 000 0 000
1 0 0 000 6 000
2 3 0 000 0 000
2 2 0 000 0 000
3 2 0 999 2 000
1 0 0 000 0 800
1 0 0 000 0 c00

/* dv/heapTb.sv */
// Array heap testbench
// Replays golden commands with random idle gaps between them and
// checks done, error and result against the expected columns

module heapTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    maxCommands = 64;                  // Golden file capacity
  localparam int    fieldCount  = 6;                   // Words per command line
  localparam int    clockPeriod = 100;
  localparam int    resetCycles = 5;
  localparam string goldenPath  = "dv/heapGolden.txt";

  logic                   clock;
  logic                   resetN;
  logic                   valid;
  heapCmdPkg::heapActionT action;
  heapMemPkg::handleT     array;
  heapMemPkg::indexT      index;
  heapMemPkg::elementT    operand;
  logic                   done;
  heapCmdPkg::resultWordT result;
  heapMemPkg::heapErrorT  error;

  logic [15:0] golden [maxCommands*fieldCount];       // Flat field storage
  int          commandCount;
  int          valueErrors;                            // Wrong error or result
  int          doneErrors;                             // Missing done strobe
  logic        loaded = 1'b0;                          // Golden data in memory

  arrayHeap u_dut (
    .clock, .resetN, .valid, .action, .array, .index, .operand,
    .done, .result, .error
  );

  always #(clockPeriod / 2) clock = ~clock;

  // --------------------------------------------------
  // Golden data and compare tasks
  // --------------------------------------------------

  task automatic loadGolden(output bit opened);
    int fd;
    fd = $fopen(goldenPath, "r");
    opened = (fd != 0);
    commandCount = 0;
    if (opened) begin
      $fclose(fd);
      for (int i = 0; i < maxCommands * fieldCount; i++)
        golden[i] = {4'hf, 12'(i)};                    // Top nibble f marks unused
      $readmemh(goldenPath, golden);
      while (commandCount < maxCommands &&
             golden[commandCount * fieldCount][15:12] != 4'hf)
        commandCount++;
    end
  endtask

  task automatic driveCommand(input int base);
    valid   = 1'b1;
    action  = heapCmdPkg::heapActionT'(golden[base][3:0]);
    array   = heapMemPkg::handleT'(golden[base + 1]);
    index   = heapMemPkg::indexT'(golden[base + 2]);
    operand = heapMemPkg::elementT'(golden[base + 3]);
  endtask

  task automatic checkError(input heapMemPkg::heapErrorT got,
                            input heapMemPkg::heapErrorT expected,
                            input int line);
    if (got !== expected) begin
      $display("Fail at %0t: command %0d error %s, expected %s",
               $time, line, got.name(), expected.name());
      valueErrors++;
    end
  endtask

  task automatic checkResult(input heapCmdPkg::resultWordT got,
                             input heapCmdPkg::resultWordT expected,
                             input int line);
    if (got !== expected) begin
      $display("Fail at %0t: command %0d result %h, expected %h",
               $time, line, got, expected);
      valueErrors++;
    end
  endtask

  task automatic checkDone(input int line);
    if (done !== 1'b1) begin
      $display("No done strobe one cycle after command %0d", line);
      doneErrors++;
    end
  endtask

  // --------------------------------------------------
  // Stimulus and checking
  // --------------------------------------------------

  initial begin
    bit                     opened;
    int                     gap;
    int                     base;
    heapMemPkg::heapErrorT  expError;
    heapCmdPkg::resultWordT expResult;
    void'($urandom(32'hcd9c));                         // One seed for the run
    clock       = 1'b0;
    resetN      = 1'b0;
    valid       = 1'b0;
    action      = heapCmdPkg::idle;
    array       = '0;
    index       = '0;
    operand     = '0;
    valueErrors = 0;
    doneErrors  = 0;
    loadGolden(opened);
    if (!opened) begin
      $display("Golden file %s could not be opened", goldenPath);
      $display("Regression failed");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (resetCycles) @(negedge clock);
      resetN = 1'b1;
      if (done !== 1'b0) begin
        $display("Done high straight after reset");
        doneErrors++;
      end
      checkError(error, heapMemPkg::noError, 0);       // Command 0 is reset
      for (int n = 0; n < commandCount; n++) begin
        base = n * fieldCount;
        driveCommand(base);                            // On this falling edge
        @(negedge clock);
        valid     = 1'b0;
        expError  = heapMemPkg::heapErrorT'(golden[base + 4][2:0]);
        expResult = heapCmdPkg::resultWordT'(golden[base + 5][11:0]);
        checkDone(n + 1);
        checkError(error, expError, n + 1);
        if (expError == heapMemPkg::noError)
          checkResult(result, expResult, n + 1);       // Result only meaningful without error
        gap = $urandom_range(2, 0);
        repeat (gap) @(negedge clock);
      end
      $display("Summary: %0d commands, %0d value errors, %0d missing done",
               commandCount, valueErrors, doneErrors);
      if (valueErrors == 0 && doneErrors == 0)
        $display("Regression passed");
      else
        $display("Regression failed");
      $finish;
    end
  end

  // At most 3 cycles per command, so 4 leaves margin
  initial begin
    wait (loaded);
    #((commandCount * 4 + resetCycles) * clockPeriod);
    $display("Watchdog expired before all %0d commands finished", commandCount);
    $display("Regression failed");
    $finish;
  end

endmodule

/* list.f */
+incdir+source
source/heapMemPkg.sv
source/heapCmdPkg.sv
source/heapAllocator.sv
source/elementStore.sv
source/arrayEngine.sv
source/arrayHeap.sv
dv/heapTb.sv

/* run.sh */
#!/bin/sh
# Build the array heap testbench with Verilator, run it, search the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module heapTb -f list.f -o heapSim > build.log 2>&1 &&
  ./obj_dir/heapSim > "$LOG" 2>&1 ||
  { cat build.log; echo "Build or simulation error"; exit 1; }

grep -q "Regression passed" "$LOG" && echo "PASS" || { echo "FAIL"; exit 1; }

/* source/arrayEngine.sv */
// Array heap command engine
// Checks each command, computes in-place results and drives the
// allocator and element store, with registered result and error

`include "heap_defs.svh"

module arrayEngine (
  input  logic                     clock,
  input  logic                     resetN,
  input  logic                     valid,          // Command present
  input  heapCmdPkg::heapActionT   action,
  input  heapMemPkg::handleT       array,
  input  heapMemPkg::indexT        index,
  input  heapMemPkg::elementT      operand,
  input  logic [`HEAP_ARRAYS-1:0]  live,           // From allocator
  input  heapMemPkg::handleT       grantHandle,
  input  logic                     grantOk,
  output logic                     take,           // Commit allocation
  output logic                     releaseNow,     // Commit free
  output heapMemPkg::handleT       releaseHandle,
  output heapMemPkg::indexT        readIndex,      // Store read address
  input  heapMemPkg::elementT      readElement,
  input  heapMemPkg::sizeT         readSize,
  output logic                     elemWrite,
  output logic                     sizeWrite,
  output heapMemPkg::handleT       writeArray,
  output heapMemPkg::indexT        writeIndex,
  output heapMemPkg::elementT      writeElement,
  output heapMemPkg::sizeT         newSize,
  output logic                     done,           // Result ready, one cycle later
  output heapCmdPkg::resultWordT   result,
  output heapMemPkg::heapErrorT    error
);

  localparam heapMemPkg::sizeT fullSize = heapMemPkg::sizeT'(`HEAP_LENGTH);

  logic [`HEAP_ARRAYS-1:0] everUsed;              // Handle granted at least once
  logic                    needRead;              // Index must be below size
  logic                    cmdOk;                 // Valid and error free
  heapMemPkg::sizeT        indexSize;             // Index widened to size width
  heapMemPkg::heapErrorT   nextError;
  heapMemPkg::elementT     aluOut;
  heapCmdPkg::resultWordT  nextResult;

  assign indexSize = heapMemPkg::sizeT'(index);
  assign needRead  = action inside {heapCmdPkg::read, heapCmdPkg::add, heapCmdPkg::addAfter,
                                    heapCmdPkg::subtract, heapCmdPkg::subAfter,
                                    heapCmdPkg::orOp, heapCmdPkg::xorOp, heapCmdPkg::andOp};

  // Pop reads the last element, everything else the client index
  assign readIndex = (action == heapCmdPkg::pop) ? heapMemPkg::indexT'(readSize - 1'b1) : index;

  // --------------------------------------------------
  // Checks and error code
  // --------------------------------------------------

  always_comb begin
    nextError = heapMemPkg::noError;
    if (action == heapCmdPkg::alloc) begin
      if (!grantOk) nextError = heapMemPkg::outOfMemory;
    end else if (action != heapCmdPkg::idle) begin
      if (!live[array])                       // Writable check first
        nextError = everUsed[array] ? heapMemPkg::wasFreed : heapMemPkg::notAllocated;
      else if (needRead && indexSize >= readSize)
        nextError = heapMemPkg::outOfBounds;
      else if (action == heapCmdPkg::push && readSize == fullSize)
        nextError = heapMemPkg::arrayFull;
      else if (action == heapCmdPkg::pop && readSize == '0)
        nextError = heapMemPkg::arrayEmpty;
    end
  end

  assign cmdOk = valid && (nextError == heapMemPkg::noError);

  // --------------------------------------------------
  // Arithmetic, logic and result word
  // --------------------------------------------------

  always_comb begin
    case (action)
      heapCmdPkg::add, heapCmdPkg::addAfter:      aluOut = readElement + operand;
      heapCmdPkg::subtract, heapCmdPkg::subAfter: aluOut = readElement - operand;
      heapCmdPkg::orOp:                           aluOut = readElement | operand;
      heapCmdPkg::xorOp:                          aluOut = readElement ^ operand;
      heapCmdPkg::andOp:                          aluOut = readElement & operand;
      default:                                    aluOut = operand;  // Write and Push
    endcase
  end

  always_comb begin
    nextResult = result;                          // Free and idle keep the last result
    case (action)
      heapCmdPkg::alloc: begin
        nextResult             = '0;
        nextResult.meta.handle = grantHandle;
      end
      heapCmdPkg::size: begin
        nextResult           = '0;
        nextResult.meta.size = readSize;
      end
      heapCmdPkg::read, heapCmdPkg::pop, heapCmdPkg::addAfter, heapCmdPkg::subAfter:
        nextResult.element = readElement;         // Old value out
      heapCmdPkg::free, heapCmdPkg::idle: ;
      default: nextResult.element = aluOut;       // New value out
    endcase
  end

  // --------------------------------------------------
  // Peer strobes
  // --------------------------------------------------

  assign take          = cmdOk && (action == heapCmdPkg::alloc);
  assign releaseNow    = cmdOk && (action == heapCmdPkg::free);
  assign releaseHandle = array;
  assign writeArray    = (action == heapCmdPkg::alloc) ? grantHandle : array;
  assign writeIndex    = (action == heapCmdPkg::push) ? heapMemPkg::indexT'(readSize) : index;
  assign writeElement  = aluOut;
  assign elemWrite     = cmdOk && (needRead || action inside {heapCmdPkg::write, heapCmdPkg::push})
                         && (action != heapCmdPkg::read);
  assign sizeWrite     = cmdOk && (action inside {heapCmdPkg::alloc, heapCmdPkg::push,
                                                  heapCmdPkg::pop}
                         || (action == heapCmdPkg::write && indexSize >= readSize));

  always_comb begin
    case (action)
      heapCmdPkg::push: newSize = readSize + 1'b1;
      heapCmdPkg::pop:  newSize = readSize - 1'b1;
      heapCmdPkg::write: newSize = indexSize + 1'b1;  // Grow to cover index
      default:          newSize = '0;                 // Alloc empties the array
    endcase
  end

  // --------------------------------------------------
  // Registered outputs
  // --------------------------------------------------

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done     <= 1'b0;
      error    <= heapMemPkg::noError;
      result   <= '0;
      everUsed <= '0;
    end else begin
      done <= valid;
      if (valid) error <= nextError;
      if (cmdOk) result <= nextResult;
      if (take) everUsed[grantHandle] <= 1'b1;
    end
  end

  // Offered handle must not already be in use
  assert property (@(posedge clock) disable iff (!resetN)
    grantOk |-> !live[grantHandle])
    else $error("Allocator offered handle %0d that is still live", grantHandle);

endmodule

/* source/arrayHeap.sv */
// Array heap top level
// Command engine with its two peers, the allocator and the element store

`include "heap_defs.svh"

module arrayHeap (
  input  logic                    clock,
  input  logic                    resetN,
  input  logic                    valid,
  input  heapCmdPkg::heapActionT  action,
  input  heapMemPkg::handleT      array,
  input  heapMemPkg::indexT       index,
  input  heapMemPkg::elementT     operand,
  output logic                    done,
  output heapCmdPkg::resultWordT  result,
  output heapMemPkg::heapErrorT   error
);

  logic [`HEAP_ARRAYS-1:0] live;
  heapMemPkg::handleT      grantHandle, releaseHandle, writeArray;
  logic                    grantOk, take, releaseNow;
  heapMemPkg::indexT       readIndex, writeIndex;
  heapMemPkg::elementT     readElement, writeElement;
  heapMemPkg::sizeT        readSize, newSize;
  logic                    elemWrite, sizeWrite;

  arrayEngine u_engine (
    .clock, .resetN, .valid, .action, .array, .index, .operand,
    .live, .grantHandle, .grantOk, .take, .releaseNow, .releaseHandle,
    .readIndex, .readElement, .readSize,
    .elemWrite, .sizeWrite, .writeArray, .writeIndex, .writeElement, .newSize,
    .done, .result, .error
  );

  heapAllocator u_allocator (
    .clock, .resetN, .take, .releaseNow, .releaseHandle,
    .live, .grantHandle, .grantOk
  );

  // Read array comes straight from the client, index from the engine
  elementStore u_store (
    .clock, .resetN, .array, .index (readIndex), .readElement, .readSize,
    .elemWrite, .sizeWrite, .writeArray, .writeIndex, .writeElement, .newSize
  );

endmodule

/* source/elementStore.sv */
// Array heap element store
// Element memory plus a size table, each with one combinational read
// port and one write port

`include "heap_defs.svh"

module elementStore (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapMemPkg::handleT   array,         // Read address, array part
  input  heapMemPkg::indexT    index,         // Read address, element part
  output heapMemPkg::elementT  readElement,
  output heapMemPkg::sizeT     readSize,      // Size of the read array
  input  logic                 elemWrite,     // Store writeElement
  input  logic                 sizeWrite,     // Store newSize
  input  heapMemPkg::handleT   writeArray,    // Target array of both writes
  input  heapMemPkg::indexT    writeIndex,
  input  heapMemPkg::elementT  writeElement,
  input  heapMemPkg::sizeT     newSize
);

  heapMemPkg::elementT memory [`HEAP_ARRAYS][`HEAP_LENGTH];  // Fixed block per array
  heapMemPkg::sizeT    sizes  [`HEAP_ARRAYS];                // Live length per array

  // --------------------------------------------------
  // Read ports
  // --------------------------------------------------

  assign readElement = memory[array][index];
  assign readSize    = sizes[array];

  // --------------------------------------------------
  // Write ports
  // --------------------------------------------------

  always_ff @(posedge clock) begin
    if (elemWrite)
      memory[writeArray][writeIndex] <= writeElement;
  end

  // All arrays start empty
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++)
        sizes[i] <= '0;
    end else if (sizeWrite) begin
      sizes[writeArray] <= newSize;
    end
  end

  // Engine arithmetic on sizes must stay in range
  assert property (@(posedge clock) disable iff (!resetN)
    sizeWrite |-> (newSize <= heapMemPkg::sizeT'(`HEAP_LENGTH)))
    else $error("Size %0d written beyond array length", newSize);

endmodule

/* source/heapAllocator.sv */
// Array heap handle allocator
// Hands out freed handles first from a stack, then fresh ones in order
// Keeps one liveness bit per array

`include "heap_defs.svh"

module heapAllocator (
  input  logic                      clock,
  input  logic                      resetN,
  input  logic                      take,          // Commit current grant
  input  logic                      releaseNow,    // Free releaseHandle
  input  heapMemPkg::handleT        releaseHandle,
  output logic [`HEAP_ARRAYS-1:0]   live,          // Array currently allocated
  output heapMemPkg::handleT        grantHandle,   // Handle the next Alloc gets
  output logic                      grantOk        // Some handle is available
);

  // Counts need to reach HEAP_ARRAYS itself
  typedef logic [`HEAP_HANDLE_BITS:0] countT;

  heapMemPkg::handleT freeStack [`HEAP_ARRAYS];   // Freed handles, top at freeTop-1
  countT              freeTop;                    // Entries on the free stack
  countT              freshCount;                 // Handles never used yet
  heapMemPkg::handleT topSlot;                    // Stack slot of the top entry
  logic               haveFreed;

  // --------------------------------------------------
  // Grant selection
  // --------------------------------------------------

  assign haveFreed = (freeTop != '0);
  assign topSlot   = heapMemPkg::handleT'(freeTop - 1'b1);

  // Reuse beats fresh so freed arrays come back first
  assign grantHandle = haveFreed ? freeStack[topSlot]
                                 : heapMemPkg::handleT'(freshCount);
  assign grantOk = haveFreed || (freshCount < countT'(`HEAP_ARRAYS));

  // --------------------------------------------------
  // Stack, counter and liveness
  // --------------------------------------------------

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freeTop    <= '0;
      freshCount <= '0;
      live       <= '0;
    end else if (take) begin
      live[grantHandle] <= 1'b1;
      if (haveFreed)
        freeTop <= freeTop - 1'b1;                // Pop reused handle
      else
        freshCount <= freshCount + 1'b1;          // Next fresh handle
    end else if (releaseNow) begin
      live[releaseHandle] <= 1'b0;
      freeTop             <= freeTop + 1'b1;      // Push freed handle
    end
  end

  // Stack payload, written at the current top
  always_ff @(posedge clock) begin
    if (releaseNow && !take)
      freeStack[freeTop[`HEAP_HANDLE_BITS-1:0]] <= releaseHandle;
  end

  // --------------------------------------------------
  // Checks on the engine
  // --------------------------------------------------

  // Engine must see outOfMemory before committing
  assert property (@(posedge clock) disable iff (!resetN)
    take |-> grantOk)
    else $error("Alloc committed with no handle available");

  // Double free must be caught by the engine
  assert property (@(posedge clock) disable iff (!resetN)
    releaseNow |-> live[releaseHandle])
    else $error("Release of handle %0d that is not live", releaseHandle);

endmodule

/* source/heapCmdPkg.sv */
// Array heap command types
// Opcode enum and the result word with its two views

`include "heap_defs.svh"

package heapCmdPkg;

  // Commands accepted by the engine, one per cycle
  typedef enum logic [3:0] {
    idle,                                         // No operation
    alloc,                                        // New or reused array
    free,                                         // Return array for reuse
    write,                                        // Store element, may grow size
    read,                                         // Bounds-checked load
    size,                                         // Current array size
    push,                                         // Append at size
    pop,                                          // Remove last element
    add,                                          // Add, new value out
    addAfter,                                     // Add, old value out
    subtract,                                     // Subtract, new value out
    subAfter,                                     // Subtract, old value out
    orOp,                                         // Bitwise or in place
    xorOp,                                        // Bitwise xor in place
    andOp                                         // Bitwise and in place
  } heapActionT;

  // Spare bits after the handle and size fields
  localparam int metaPadBits = `HEAP_DATA_BITS - `HEAP_HANDLE_BITS - `HEAP_INDEX_BITS - 1;

  // Alloc and Size use the meta view, all else the element view
  typedef union packed {
    heapMemPkg::elementT element;                 // Data result
    struct packed {
      heapMemPkg::handleT handle;                 // Granted handle
      heapMemPkg::sizeT size;                     // Array size
      logic [metaPadBits-1:0] pad;                // Always zero
    } meta;
  } resultWordT;

endpackage

/* source/heapMemPkg.sv */
// Array heap storage types
// Handle, index, size and element words plus the error codes

`include "heap_defs.svh"

package heapMemPkg;

  // Array number
  typedef logic [`HEAP_HANDLE_BITS-1:0] handleT;

  // Element position inside an array
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;

  // Size runs 0 to length, so one extra bit
  typedef logic [`HEAP_INDEX_BITS:0] sizeT;

  // Stored data word
  typedef logic [`HEAP_DATA_BITS-1:0] elementT;

  // Error code returned with every command
  typedef enum logic [2:0] {
    noError,                                      // Command done
    notAllocated,                                 // Handle never handed out
    wasFreed,                                     // Handle handed out then freed
    outOfBounds,                                  // Index not below size
    arrayFull,                                    // Push at full length
    arrayEmpty,                                   // Pop at size zero
    outOfMemory                                   // No handle left to grant
  } heapErrorT;

endpackage

/* source/heap_defs.svh */
// Array heap sizing macros
// Widths of handles, indices and elements, with derived array counts

`ifndef HEAP_DEFS_SVH
`define HEAP_DEFS_SVH

// --------------------------------------------------
// Base widths
// --------------------------------------------------

// Bits in an array handle
`define HEAP_HANDLE_BITS 2

// Bits in an element index
`define HEAP_INDEX_BITS 2

// Element width in bits
`define HEAP_DATA_BITS 12

// --------------------------------------------------
// Derived counts
// --------------------------------------------------

// One array per handle value
`define HEAP_ARRAYS (1 << `HEAP_HANDLE_BITS)

// One element per index value
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)

`endif
